/* source/traffic_pkg.sv */
`default_nettype none

package traffic_pkg;

    // ====================
    // Sizes
    // ====================

    // Line address width of the random region
    localparam int MEM_ADDR_BITS = 12;
    // Shadow RAM index width and how many of its bits come from the low address
    localparam int CHECK_BITS = 8;
    localparam int CHECK_LOW_BITS = 5;
    localparam int DATA_BITS = 32;
    localparam int COUNT_BITS = 32;

    // ====================
    // Types
    // ====================

    typedef logic [MEM_ADDR_BITS-1:0] t_mem_addr;
    // Top address bits followed by the low address bits
    typedef logic [CHECK_BITS-1:0] t_check_idx;
    typedef logic [DATA_BITS-1:0] t_data;
    typedef logic [COUNT_BITS-1:0] t_counter;

    // One entry per issued read
    typedef struct packed {
        logic checked;
        t_data data;
    } t_expect;

    typedef enum logic [1:0] {
        STATE_IDLE,
        STATE_RUN,
        STATE_DRAIN,
        STATE_ERROR
    } t_run_state;

endpackage

`default_nettype wire

/* source/lfsr32.sv */
`timescale 1ns/1ps
`default_nettype none

// Galois form of x^32 + x^22 + x^2 + x + 1
module lfsr32
#(
    parameter logic [31:0] SEED = 32'h0000_0001
)
(
    input  wire logic        clk,
    input  wire logic        reset,
    output logic      [31:0] value
);

    // Feedback mask applied when the bit shifted out is set
    localparam logic [31:0] TAPS = 32'h8020_0003;

    always_ff @(posedge clk)
    begin
        // Free-running step every cycle
        value <= {1'b0, value[31:1]} ^ (value[0] ? TAPS : 32'h0);

        // Restart from the nonzero seed
        if (reset)
        begin
            value <= SEED;
        end
    end

endmodule

`default_nettype wire

/* source/run_control.sv */
`timescale 1ns/1ps
`default_nettype none

module run_control
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  start,
    input  wire traffic_pkg::t_counter run_cycles,
    input  wire logic                  mismatch,
    input  wire logic                  fifo_empty,
    output logic                       state_run,
    output logic                       clear_counts,
    output logic                       busy,
    output logic                       done,
    output logic                       error
);

    import traffic_pkg::*;

    t_run_state state;
    t_counter cycles_rem;
    // Covers reads still between the ports and the FIFO push
    logic [1:0] settle;
    logic start_ok;

    // Start counts only while idle
    assign start_ok = start && (state == STATE_IDLE);
    assign busy = (state != STATE_IDLE);
    // Exactly run_cycles issue cycles
    assign state_run = (state == STATE_RUN) && (cycles_rem != '0);

    // ====================
    // Run state machine
    // ====================

    always_ff @(posedge clk)
    begin
        clear_counts <= start_ok;
        done <= 1'b0;

        if (settle != 2'd0)
        begin
            settle <= settle - 2'd1;
        end

        case (state)
            STATE_IDLE:
            begin
                if (start_ok)
                begin
                    state <= STATE_RUN;
                    cycles_rem <= run_cycles;
                end
            end

            STATE_RUN:
            begin
                if (cycles_rem != '0)
                begin
                    cycles_rem <= cycles_rem - t_counter'(1);
                end

                // Error wins over normal end of run
                if (mismatch)
                begin
                    state <= STATE_ERROR;
                    settle <= 2'd2;
                end
                else if (cycles_rem <= t_counter'(1))
                begin
                    state <= STATE_DRAIN;
                    settle <= 2'd2;
                end
            end

            STATE_DRAIN:
            begin
                if (mismatch)
                begin
                    state <= STATE_ERROR;
                    settle <= 2'd2;
                end
                else if ((settle == 2'd0) && fifo_empty)
                begin
                    state <= STATE_IDLE;
                    done <= 1'b1;
                end
            end

            default:
            begin
                // Error waits for outstanding reads as well
                if ((settle == 2'd0) && fifo_empty)
                begin
                    state <= STATE_IDLE;
                    done <= 1'b1;
                end
            end
        endcase

        // Sticky until the next accepted start
        if (mismatch)
        begin
            error <= 1'b1;
        end
        if (start_ok)
        begin
            error <= 1'b0;
        end

        if (reset)
        begin
            state <= STATE_IDLE;
            cycles_rem <= '0;
            settle <= 2'd0;
            clear_counts <= 1'b0;
            done <= 1'b0;
            error <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/shadow_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module shadow_ram
(
    input  wire logic                    clk,
    input  wire logic                    reset,
    output logic                         ready,
    input  wire logic                    wr_en,
    input  wire traffic_pkg::t_check_idx wr_idx,
    input  wire traffic_pkg::t_data      wr_data,
    input  wire traffic_pkg::t_check_idx rd_idx,
    output traffic_pkg::t_data           rd_data
);

    import traffic_pkg::*;

    localparam int N_ENTRIES = 1 << CHECK_BITS;

    t_data mem [N_ENTRIES];
    t_check_idx sweep_idx;

    // Single write port shared by the clear sweep and normal updates
    logic ram_we;
    t_check_idx ram_idx;
    t_data ram_wdata;

    always_comb
    begin
        if (!ready)
        begin
            ram_we = 1'b1;
            ram_idx = sweep_idx;
            ram_wdata = '0;
        end
        else
        begin
            ram_we = wr_en;
            ram_idx = wr_idx;
            ram_wdata = wr_data;
        end
    end

    // Read sees old data on a same-cycle write to the same entry
    always_ff @(posedge clk)
    begin
        if (ram_we)
        begin
            mem[ram_idx] <= ram_wdata;
        end
        rd_data <= mem[rd_idx];
    end

    // Clear sweep after reset, ready once the last entry is written
    always_ff @(posedge clk)
    begin
        if (!ready)
        begin
            sweep_idx <= sweep_idx + t_check_idx'(1);
            if (sweep_idx == '1)
            begin
                ready <= 1'b1;
            end
        end

        if (reset)
        begin
            ready <= 1'b0;
            sweep_idx <= '0;
        end
    end

endmodule

`default_nettype wire

/* source/request_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module request_generator
#(
    parameter logic [31:0] RD_SEED = 32'h0000_2721,
    parameter logic [31:0] WR_SEED = 32'h0000_8520,
    parameter logic [31:0] DATA_SEED = 32'h0000_0001
)
(
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 state_run,
    input  wire logic                 enable_reads,
    input  wire logic                 enable_writes,
    input  wire logic                 separate_rw,
    input  wire logic                 mem_almost_full,
    input  wire logic                 fifo_almost_full,
    output logic                      wr_valid,
    output traffic_pkg::t_mem_addr    wr_addr,
    output traffic_pkg::t_data        wr_data,
    output logic                      rd_valid,
    output traffic_pkg::t_mem_addr    rd_addr,
    output logic                      push_valid,
    output traffic_pkg::t_expect      push_data
);

    import traffic_pkg::*;

    // Address layout is high | middle | low, middle is never indexed
    localparam int HIGH_BITS = CHECK_BITS - CHECK_LOW_BITS;
    localparam int MID_BITS = MEM_ADDR_BITS - CHECK_BITS;

    // ====================
    // Address mapping
    // ====================

    // Checked only when the unindexed middle bits are all zero
    function automatic logic addr_is_checked(t_mem_addr a);
        return (a[CHECK_LOW_BITS +: MID_BITS] == '0);
    endfunction

    function automatic t_check_idx check_idx(t_mem_addr a);
        return {a[MEM_ADDR_BITS-1 -: HIGH_BITS], a[CHECK_LOW_BITS-1:0]};
    endfunction

    // Bit 2 splits reads and writes into disjoint lines when separated
    function automatic t_mem_addr map_addr(logic [31:0] r, logic sep, logic bit2);
        t_mem_addr a;
        a = r[MEM_ADDR_BITS-1:0];
        if (sep)
        begin
            a[2] = bit2;
        end
        return a;
    endfunction

    logic [31:0] rd_rand;
    logic [31:0] wr_rand;
    logic [31:0] data_rand;

    lfsr32 #(.SEED(RD_SEED)) rd_lfsr (.clk, .reset, .value(rd_rand));
    lfsr32 #(.SEED(WR_SEED)) wr_lfsr (.clk, .reset, .value(wr_rand));
    lfsr32 #(.SEED(DATA_SEED)) data_lfsr (.clk, .reset, .value(data_rand));

    // ====================
    // Request issue
    // ====================

    logic shadow_ready;
    logic can_issue;
    logic push_checked;
    t_data shadow_rd;

    // Any stall sampled at an edge blocks the request of the next cycle
    assign can_issue = state_run && shadow_ready && !mem_almost_full && !fifo_almost_full;

    always_ff @(posedge clk)
    begin
        wr_valid <= can_issue && enable_writes;
        rd_valid <= can_issue && enable_reads;
        // Push lines up with the shadow read result
        push_valid <= rd_valid;

        if (reset)
        begin
            wr_valid <= 1'b0;
            rd_valid <= 1'b0;
            push_valid <= 1'b0;
        end
    end

    // Payload, meaningful only with its valid
    always_ff @(posedge clk)
    begin
        wr_addr <= map_addr(wr_rand, separate_rw, 1'b1);
        wr_data <= t_data'(data_rand);
        rd_addr <= map_addr(rd_rand, separate_rw, 1'b0);
        push_checked <= addr_is_checked(rd_addr);
    end

    // Shadow follows the writes on the ports, and reads run alongside
    shadow_ram shadow
    (
        .clk,
        .reset,
        .ready(shadow_ready),
        .wr_en(wr_valid && addr_is_checked(wr_addr)),
        .wr_idx(check_idx(wr_addr)),
        .wr_data(wr_data),
        .rd_idx(check_idx(rd_addr)),
        .rd_data(shadow_rd)
    );

    assign push_data = '{checked: push_checked, data: shadow_rd};

endmodule

`default_nettype wire

/* source/expect_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module expect_fifo
#(
    parameter type t_payload = logic [31:0],
    parameter int FIFO_DEPTH = 16,
    parameter int FIFO_SLACK = 4
)
(
    input  wire logic     clk,
    input  wire logic     reset,
    input  wire logic     push,
    input  wire t_payload push_data,
    input  wire logic     pop,
    output t_payload      pop_data,
    output logic          empty,
    output logic          almost_full
);

    localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    t_payload mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;

    // Wrap by value so any depth works
    function automatic logic [PTR_BITS-1:0] next_ptr(logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : p + PTR_BITS'(1);
    endfunction

    // Head is visible without a pop
    assign pop_data = mem[rd_ptr];
    assign empty = (count == '0);
    // Room left for requests already in the pipeline
    assign almost_full = (count >= CNT_BITS'(FIFO_DEPTH - FIFO_SLACK));

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            wr_ptr <= next_ptr(wr_ptr);
        end
        if (pop)
        begin
            rd_ptr <= next_ptr(rd_ptr);
        end

        case ({push, pop})
            2'b10: count <= count + CNT_BITS'(1);
            2'b01: count <= count - CNT_BITS'(1);
            default: count <= count;
        endcase

        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end
    end

endmodule

`default_nettype wire

/* source/response_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module response_checker
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  clear_counts,
    input  wire logic                  rsp_valid,
    input  wire traffic_pkg::t_data    rsp_data,
    input  wire traffic_pkg::t_expect  head,
    output logic                       pop,
    output logic                       mismatch,
    output traffic_pkg::t_counter      cnt_rd_rsp,
    output traffic_pkg::t_counter      cnt_wr,
    output traffic_pkg::t_counter      cnt_checked,
    input  wire logic                  wr_valid
);

    import traffic_pkg::*;

    // Responses arrive in order, so every one retires the head
    assign pop = rsp_valid;

    always_ff @(posedge clk)
    begin
        // Whole data word compare on checked entries
        mismatch <= rsp_valid && head.checked && (rsp_data != head.data);

        if (rsp_valid)
        begin
            cnt_rd_rsp <= cnt_rd_rsp + t_counter'(1);
        end
        if (rsp_valid && head.checked)
        begin
            cnt_checked <= cnt_checked + t_counter'(1);
        end
        // Writes are counted as issued
        if (wr_valid)
        begin
            cnt_wr <= cnt_wr + t_counter'(1);
        end

        if (reset || clear_counts)
        begin
            cnt_rd_rsp <= '0;
            cnt_wr <= '0;
            cnt_checked <= '0;
        end
        if (reset)
        begin
            mismatch <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* source/traffic_checker_top.sv */
`timescale 1ns/1ps
`default_nettype none

module traffic_checker_top
#(
    parameter int FIFO_DEPTH = 16,
    parameter int FIFO_SLACK = 4,
    parameter logic [31:0] RD_SEED = 32'h0000_2721,
    parameter logic [31:0] WR_SEED = 32'h0000_8520,
    parameter logic [31:0] DATA_SEED = 32'h0000_0001
)
(
    input  wire logic                  clk,
    input  wire logic                  reset,
    input  wire logic                  start,
    input  wire traffic_pkg::t_counter run_cycles,
    input  wire logic                  enable_reads,
    input  wire logic                  enable_writes,
    input  wire logic                  separate_rw,
    input  wire logic                  mem_almost_full,
    input  wire logic                  rsp_valid,
    input  wire traffic_pkg::t_data    rsp_data,
    output logic                       wr_valid,
    output traffic_pkg::t_mem_addr     wr_addr,
    output traffic_pkg::t_data         wr_data,
    output logic                       rd_valid,
    output traffic_pkg::t_mem_addr     rd_addr,
    output logic                       busy,
    output logic                       done,
    output logic                       error,
    output traffic_pkg::t_counter      cnt_rd_rsp,
    output traffic_pkg::t_counter      cnt_wr,
    output traffic_pkg::t_counter      cnt_checked
);

    import traffic_pkg::*;

    logic state_run;
    logic clear_counts;
    logic mismatch;
    // Expectation path from producer through FIFO to consumer
    logic push_valid;
    t_expect push_data;
    logic pop;
    t_expect head;
    logic fifo_empty;
    logic fifo_almost_full;

    run_control ctrl
    (
        .clk, .reset, .start, .run_cycles, .mismatch, .fifo_empty,
        .state_run, .clear_counts, .busy, .done, .error
    );

    request_generator
    #(
        .RD_SEED(RD_SEED),
        .WR_SEED(WR_SEED),
        .DATA_SEED(DATA_SEED)
    )
    gen
    (
        .clk, .reset, .state_run, .enable_reads, .enable_writes, .separate_rw,
        .mem_almost_full, .fifo_almost_full,
        .wr_valid, .wr_addr, .wr_data, .rd_valid, .rd_addr, .push_valid, .push_data
    );

    expect_fifo
    #(
        .t_payload(t_expect),
        .FIFO_DEPTH(FIFO_DEPTH),
        .FIFO_SLACK(FIFO_SLACK)
    )
    fifo
    (
        .clk, .reset, .push(push_valid), .push_data, .pop, .pop_data(head),
        .empty(fifo_empty), .almost_full(fifo_almost_full)
    );

    response_checker chk
    (
        .clk, .reset, .clear_counts, .rsp_valid, .rsp_data, .head, .pop, .mismatch,
        .cnt_rd_rsp, .cnt_wr, .cnt_checked, .wr_valid
    );

endmodule

`default_nettype wire

/* tests/traffic_checker_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

// Bound twice, inputs of the other instance are tied low
module traffic_checker_assertions
(
    input wire logic clk,
    input wire logic reset,
    input wire logic stall,
    input wire logic request,
    input wire logic push,
    input wire logic pop,
    input wire logic full,
    input wire logic empty
);

    // Almost-full sampled at an edge blocks the next cycle
    stall_blocks_request: assert property (@(posedge clk) disable iff (reset)
        stall |=> !request)
        else $error("request issued in the cycle after mem_almost_full");

    no_push_when_full: assert property (@(posedge clk) disable iff (reset)
        !(push && full))
        else $error("expectation FIFO pushed while full");

    no_pop_when_empty: assert property (@(posedge clk) disable iff (reset)
        !(pop && empty))
        else $error("expectation FIFO popped while empty");

endmodule

bind request_generator traffic_checker_assertions gen_checks
(
    .clk, .reset, .stall(mem_almost_full), .request(wr_valid || rd_valid),
    .push(1'b0), .pop(1'b0), .full(1'b0), .empty(1'b0)
);

// Full is the count at the whole depth
bind expect_fifo traffic_checker_assertions fifo_checks
(
    .clk, .reset, .stall(1'b0), .request(1'b0), .push, .pop,
    .full(count == CNT_BITS'(FIFO_DEPTH)), .empty
);

`default_nettype wire

/* tests/traffic_checker_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module traffic_checker_tb;

    import traffic_pkg::*;

    // ====================
    // Constants
    // ====================

    localparam int CLK_HALF = 20;
    localparam int RESET_CYCLES = 4;
    // Shadow RAM clears all entries before the first request
    localparam int SWEEP_CYCLES = 260;
    localparam int NUM_TESTS = 7;
    localparam int RUN_TOTAL = 300 + 400 + 200 + 200 + 300 + 100;
    localparam int TIMEOUT_CYCLES = RUN_TOTAL + 200 * NUM_TESTS + SWEEP_CYCLES;
    // Middle address field sits between the low and high index bits
    localparam int MID_BITS = MEM_ADDR_BITS - CHECK_BITS;
    localparam t_mem_addr BIT2 = t_mem_addr'(4);

    logic clk;
    logic reset;
    logic start;
    t_counter run_cycles;
    logic enable_reads;
    logic enable_writes;
    logic separate_rw;
    logic mem_almost_full;
    logic rsp_valid;
    t_data rsp_data;
    logic wr_valid;
    t_mem_addr wr_addr;
    t_data wr_data;
    logic rd_valid;
    t_mem_addr rd_addr;
    logic busy;
    logic done;
    logic error;
    t_counter cnt_rd_rsp;
    t_counter cnt_wr;
    t_counter cnt_checked;

    traffic_checker_top dut
    (
        .clk, .reset, .start, .run_cycles, .enable_reads, .enable_writes, .separate_rw,
        .mem_almost_full, .rsp_valid, .rsp_data, .wr_valid, .wr_addr, .wr_data,
        .rd_valid, .rd_addr, .busy, .done, .error, .cnt_rd_rsp, .cnt_wr, .cnt_checked
    );

    // Memory model, in-order response queue and scoreboard
    t_data mem_model [1 << MEM_ADDR_BITS];
    t_data rsp_data_q [$];
    int rsp_due_q [$];
    logic rsp_chk_q [$];
    integer seed;
    int cycle;
    int watchdog_cycles;
    int writes_seen;
    int reads_seen;
    int rsp_sent;
    int checked_reads;
    int done_count;
    int test_errors;
    int total_errors;
    int tests_run;
    int tests_failed;
    logic maf_random;
    logic prev_maf;
    logic corrupt_pending;
    logic corrupt_used;
    logic error_seen;
    logic error_fell;
    logic prev_error;
    // Random write data never repeats from one write to the next
    t_data last_wr_data;
    logic have_wr_data;
    string test_name;

    initial
    begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // ====================
    // Compare tasks
    // ====================

    task automatic check_counter(input string name, input t_counter expected,
                                 input t_counter actual);
        if (actual !== expected)
        begin
            $display("Fail %s %s: expected %0d, actual %0d", test_name, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_addr(input string name, input t_mem_addr expected,
                              input t_mem_addr actual);
        if (actual !== expected)
        begin
            $display("Fail %s %s: expected %h, actual %h", test_name, name, expected, actual);
            test_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("Fail %s %s: expected %b, actual %b", test_name, name, expected, actual);
            test_errors++;
        end
    endtask

    // ====================
    // Per-cycle model
    // ====================

    // Samples the cycle just begun, then drives inputs 1 ns after the edge
    task automatic step();
        t_data rdata;
        int due;
        logic rd_checked;
        @(posedge clk);
        #1;
        cycle++;
        if (prev_maf)
        begin
            check_bit("stall after mem_almost_full", 1'b0, wr_valid || rd_valid);
        end
        if (!enable_writes)
        begin
            check_bit("write while disabled", 1'b0, wr_valid);
        end
        if (!enable_reads)
        begin
            check_bit("read while disabled", 1'b0, rd_valid);
        end
        if (done)
        begin
            done_count++;
        end
        if (error)
        begin
            error_seen = 1'b1;
        end
        if (prev_error && !error)
        begin
            error_fell = 1'b1;
        end
        prev_error = error;

        // Read goes first, so a same-cycle write leaves it the old data
        if (rd_valid)
        begin
            if (separate_rw)
            begin
                check_addr("read bit 2", '0, rd_addr & BIT2);
            end
            rd_checked = (rd_addr[CHECK_LOW_BITS +: MID_BITS] == '0);
            reads_seen++;
            if (rd_checked)
            begin
                checked_reads++;
            end
            // 2 to 6 cycles, never ahead of an older response
            due = cycle + 2 + int'({$random(seed)} % 5);
            if ((rsp_due_q.size() > 0) && (due <= rsp_due_q[$]))
            begin
                due = rsp_due_q[$] + 1;
            end
            rsp_data_q.push_back(mem_model[rd_addr]);
            rsp_due_q.push_back(due);
            rsp_chk_q.push_back(rd_checked);
        end
        if (wr_valid)
        begin
            if (separate_rw)
            begin
                check_addr("write bit 2", BIT2, wr_addr & BIT2);
            end
            if (have_wr_data)
            begin
                check_bit("write data changes", 1'b1, wr_data !== last_wr_data);
            end
            last_wr_data = wr_data;
            have_wr_data = 1'b1;
            writes_seen++;
            mem_model[wr_addr] = wr_data;
        end

        rsp_valid = 1'b0;
        rsp_data = '0;
        if ((rsp_due_q.size() > 0) && (rsp_due_q[0] <= cycle))
        begin
            rdata = rsp_data_q.pop_front();
            // One checked response gets its data flipped
            if (corrupt_pending && rsp_chk_q[0])
            begin
                rdata = ~rdata;
                corrupt_pending = 1'b0;
                corrupt_used = 1'b1;
            end
            void'(rsp_due_q.pop_front());
            void'(rsp_chk_q.pop_front());
            rsp_valid = 1'b1;
            rsp_data = rdata;
            rsp_sent++;
        end

        mem_almost_full = maf_random && (({$random(seed)} % 4) == 0);
        prev_maf = mem_almost_full;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0)
        begin
            $display("%s finished: ok", test_name);
        end
        else
        begin
            $display("%s finished: %0d errors", test_name, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    // ====================
    // One start to done run
    // ====================

    task automatic run_test(input string name, input int cycles, input logic rd_en,
                            input logic wr_en, input logic sep, input logic maf_on,
                            input logic corrupt);
        test_name = name;
        enable_reads = rd_en;
        enable_writes = wr_en;
        separate_rw = sep;
        run_cycles = t_counter'(cycles);
        maf_random = maf_on;
        corrupt_pending = corrupt;
        corrupt_used = 1'b0;
        start = 1'b1;
        step();
        start = 1'b0;
        check_bit("busy after start", 1'b1, busy);
        check_bit("error after start", 1'b0, error);
        writes_seen = 0;
        reads_seen = 0;
        rsp_sent = 0;
        checked_reads = 0;
        done_count = 0;
        error_seen = 1'b0;
        error_fell = 1'b0;

        // Watchdog bounds this wait
        while (done_count == 0)
        begin
            step();
        end
        maf_random = 1'b0;
        check_bit("busy with done", 1'b0, busy);
        repeat (5) step();

        check_counter("done pulses", t_counter'(1), t_counter'(done_count));
        check_counter("cnt_wr", t_counter'(writes_seen), cnt_wr);
        check_counter("cnt_rd_rsp", t_counter'(rsp_sent), cnt_rd_rsp);
        check_counter("cnt_checked", t_counter'(checked_reads), cnt_checked);
        check_counter("reads left", '0, t_counter'(rsp_due_q.size()));
        if (!rd_en)
        begin
            check_counter("reads issued", '0, t_counter'(reads_seen));
        end
        if (!wr_en)
        begin
            check_counter("writes issued", '0, t_counter'(writes_seen));
        end
        if ((rd_en && (reads_seen == 0)) || (wr_en && (writes_seen == 0)))
        begin
            $display("%s: an enabled request type was never issued", name);
            test_errors++;
        end
        if (corrupt)
        begin
            if (!corrupt_used)
            begin
                $display("%s: no checked response came back to corrupt", name);
                test_errors++;
            end
            check_bit("error raised", 1'b1, error_seen);
            check_bit("error dropped", 1'b0, error_fell);
            check_bit("error held", 1'b1, error);
        end
        else
        begin
            check_bit("error seen", 1'b0, error_seen);
        end
        finish_test();
    endtask

    // ====================
    // Sequence
    // ====================

    initial
    begin
        seed = 32'h7cb6_d473;
        cycle = 0;
        writes_seen = 0;
        reads_seen = 0;
        rsp_sent = 0;
        checked_reads = 0;
        done_count = 0;
        test_errors = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        maf_random = 1'b0;
        prev_maf = 1'b0;
        corrupt_pending = 1'b0;
        corrupt_used = 1'b0;
        error_seen = 1'b0;
        error_fell = 1'b0;
        prev_error = 1'b0;
        last_wr_data = '0;
        have_wr_data = 1'b0;
        test_name = "reset";
        for (int i = 0; i < (1 << MEM_ADDR_BITS); i++)
        begin
            mem_model[i] = '0;
        end
        reset = 1'b1;
        start = 1'b0;
        run_cycles = '0;
        enable_reads = 1'b0;
        enable_writes = 1'b0;
        separate_rw = 1'b0;
        mem_almost_full = 1'b0;
        rsp_valid = 1'b0;
        rsp_data = '0;

        repeat (RESET_CYCLES) step();
        reset = 1'b0;
        check_bit("wr_valid", 1'b0, wr_valid);
        check_bit("rd_valid", 1'b0, rd_valid);
        check_bit("busy", 1'b0, busy);
        check_bit("done", 1'b0, done);
        check_bit("error", 1'b0, error);
        check_counter("cnt_rd_rsp", '0, cnt_rd_rsp);
        check_counter("cnt_wr", '0, cnt_wr);
        check_counter("cnt_checked", '0, cnt_checked);
        finish_test();
        repeat (SWEEP_CYCLES) step();

        run_test("separated", 300, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
        run_test("almost_full", 400, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);
        run_test("reads_only", 200, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        run_test("writes_only", 200, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
        run_test("corruption", 300, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1);
        // Start after the error run must clear error
        run_test("restart", 100, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0);

        $display("Summary: %0d tests, %0d failed, %0d check errors",
                 tests_run, tests_failed, total_errors);
        if ((tests_failed == 0) && (total_errors == 0))
        begin
            $display("TEST PASS");
        end
        else
        begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Ends a run whose DUT never reaches done
    initial
    begin
        watchdog_cycles = 0;
        while (watchdog_cycles < TIMEOUT_CYCLES)
        begin
            @(posedge clk);
            watchdog_cycles++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
source/traffic_pkg.sv
source/lfsr32.sv
source/run_control.sv
source/shadow_ram.sv
source/request_generator.sv
source/expect_fifo.sv
source/response_checker.sv
source/traffic_checker_top.sv
tests/traffic_checker_assertions.sv
tests/traffic_checker_tb.sv

/* Makefile */
# Verilator build and run of the traffic checker testbench

VERILATOR ?= verilator
TOP ?= traffic_checker_tb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert --timescale 1ns/1ps
PASS_TEXT ?= TEST PASS

BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell cat $(FLIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

# Fails unless the pass line appears in the simulation output
run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
